//--- verilog/core_pkg.sv
package core_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int IMM_W      = 16;
    localparam int SHAMT_W    = 5;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_ADD,  // wraps, no overflow trap
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_NOP,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_ARITH
    } alu_sel_e;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

endpackage

//--- verilog/core_ifs.sv
interface issue_if;

    logic               valid;
    core_pkg::alu_op_e  alu_op;
    core_pkg::alu_sel_e alu_sel;
    core_pkg::word_t    opnd1;
    core_pkg::word_t    opnd2;
    core_pkg::reg_addr_t wd;
    logic               wreg;

    modport dec (
        output valid, alu_op, alu_sel, wd, wreg
    );

    modport fwd (
        output opnd1, opnd2
    );

    modport ex (
        input valid, alu_op, alu_sel, opnd1, opnd2, wd, wreg
    );

endinterface

interface regfile_rd_if;

    logic                re1;
    core_pkg::reg_addr_t raddr1;
    core_pkg::word_t     rdata1;
    logic                re2;
    core_pkg::reg_addr_t raddr2;
    core_pkg::word_t     rdata2;

    modport dec (output re1, raddr1, re2, raddr2);
    modport rf  (input re1, raddr1, re2, raddr2, output rdata1, rdata2);
    modport fwd (input re1, raddr1, rdata1, re2, raddr2, rdata2);

endinterface

//--- verilog/regfile.sv
module regfile (
    input  logic          clk,
    input  logic          reset_i,
    regfile_rd_if.rf      rd_if,
    input  core_pkg::wb_t wr_i
);

    core_pkg::word_t regs [core_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // $0 and idle ports read as zero
    assign rd_if.rdata1 = (rd_if.re1 && rd_if.raddr1 != '0) ? regs[rd_if.raddr1] : '0;
    assign rd_if.rdata2 = (rd_if.re2 && rd_if.raddr2 != '0) ? regs[rd_if.raddr2] : '0;

    // decoder strips $0 destinations long before the write port
    a_no_zero_write: assert property (
        @(posedge clk) disable iff (reset_i)
        wr_i.we |-> wr_i.addr != '0
    ) else $error("regfile write to register zero");

endmodule

//--- verilog/inst_decoder.sv
module inst_decoder (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            inst_valid_i,
    input  core_pkg::word_t inst_i,
    issue_if.dec            iss,
    regfile_rd_if.dec       rd_if,
    output core_pkg::word_t imm_o
);

    logic                   valid_q;
    core_pkg::word_t        inst_q;

    logic [5:0]             op;
    core_pkg::reg_addr_t    rs;
    core_pkg::reg_addr_t    rt;
    core_pkg::reg_addr_t    rd;
    logic [core_pkg::SHAMT_W-1:0] shamt;
    logic [5:0]             funct;
    logic [core_pkg::IMM_W-1:0]   imm16;

    logic                   is_rtype;
    logic                   is_shamt;
    logic                   known;
    core_pkg::alu_op_e      alu_op;
    core_pkg::reg_addr_t    wd;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= inst_valid_i;
        end
        inst_q <= inst_i;
    end

    assign op    = inst_q[31:26];
    assign rs    = inst_q[25:21];
    assign rt    = inst_q[20:16];
    assign rd    = inst_q[15:11];
    assign shamt = inst_q[10:6];
    assign funct = inst_q[5:0];
    assign imm16 = inst_q[15:0];

    always_comb begin
        alu_op = core_pkg::ALU_NOP;  // dropped and unknown codes stay here
        if (op == core_pkg::OP_SPECIAL) begin
            case (funct)
                core_pkg::FN_AND:  alu_op = core_pkg::ALU_AND;
                core_pkg::FN_OR:   alu_op = core_pkg::ALU_OR;
                core_pkg::FN_XOR:  alu_op = core_pkg::ALU_XOR;
                core_pkg::FN_NOR:  alu_op = core_pkg::ALU_NOR;
                core_pkg::FN_ADD:  alu_op = core_pkg::ALU_ADD;
                core_pkg::FN_ADDU: alu_op = core_pkg::ALU_ADD;
                core_pkg::FN_SUB:  alu_op = core_pkg::ALU_SUB;
                core_pkg::FN_SUBU: alu_op = core_pkg::ALU_SUB;
                core_pkg::FN_SLT:  alu_op = core_pkg::ALU_SLT;
                core_pkg::FN_SLTU: alu_op = core_pkg::ALU_SLTU;
                core_pkg::FN_SLL:  alu_op = core_pkg::ALU_SLL;
                core_pkg::FN_SRL:  alu_op = core_pkg::ALU_SRL;
                core_pkg::FN_SRA:  alu_op = core_pkg::ALU_SRA;
                core_pkg::FN_SLLV: alu_op = core_pkg::ALU_SLL;
                core_pkg::FN_SRLV: alu_op = core_pkg::ALU_SRL;
                core_pkg::FN_SRAV: alu_op = core_pkg::ALU_SRA;
                default:           alu_op = core_pkg::ALU_NOP;
            endcase
        end else begin
            case (op)
                core_pkg::OP_ANDI:  alu_op = core_pkg::ALU_AND;
                core_pkg::OP_ORI:   alu_op = core_pkg::ALU_OR;
                core_pkg::OP_LUI:   alu_op = core_pkg::ALU_OR;  // $0 | (imm << 16)
                core_pkg::OP_XORI:  alu_op = core_pkg::ALU_XOR;
                core_pkg::OP_ADDI:  alu_op = core_pkg::ALU_ADD;
                core_pkg::OP_ADDIU: alu_op = core_pkg::ALU_ADD;
                core_pkg::OP_SLTI:  alu_op = core_pkg::ALU_SLT;
                core_pkg::OP_SLTIU: alu_op = core_pkg::ALU_SLTU;
                default:            alu_op = core_pkg::ALU_NOP;
            endcase
        end
    end

    always_comb begin
        case (alu_op)
            core_pkg::ALU_AND, core_pkg::ALU_OR,
            core_pkg::ALU_XOR, core_pkg::ALU_NOR:  iss.alu_sel = core_pkg::SEL_LOGIC;
            core_pkg::ALU_SLL, core_pkg::ALU_SRL,
            core_pkg::ALU_SRA:                     iss.alu_sel = core_pkg::SEL_SHIFT;
            core_pkg::ALU_ADD, core_pkg::ALU_SUB,
            core_pkg::ALU_SLT, core_pkg::ALU_SLTU: iss.alu_sel = core_pkg::SEL_ARITH;
            default:                               iss.alu_sel = core_pkg::SEL_NOP;
        endcase
    end

    always_comb begin
        case (op)
            core_pkg::OP_SPECIAL: imm_o = {{(core_pkg::DATA_W-core_pkg::SHAMT_W){1'b0}}, shamt};
            core_pkg::OP_ANDI,
            core_pkg::OP_ORI,
            core_pkg::OP_XORI:    imm_o = {{(core_pkg::DATA_W-core_pkg::IMM_W){1'b0}}, imm16};
            core_pkg::OP_LUI:     imm_o = {imm16, {(core_pkg::DATA_W-core_pkg::IMM_W){1'b0}}};
            default:              imm_o = {{(core_pkg::DATA_W-core_pkg::IMM_W){imm16[15]}}, imm16};
        endcase
    end

    assign is_rtype = op == core_pkg::OP_SPECIAL;
    assign is_shamt = is_rtype &&
                      (funct == core_pkg::FN_SLL || funct == core_pkg::FN_SRL ||
                       funct == core_pkg::FN_SRA);
    assign known    = alu_op != core_pkg::ALU_NOP;
    assign wd       = is_rtype ? rd : rt;

    assign rd_if.re1    = known && !is_shamt;  // shamt forms shift by the immediate
    assign rd_if.re2    = known && is_rtype;
    assign rd_if.raddr1 = (op == core_pkg::OP_LUI) ? '0 : rs;
    assign rd_if.raddr2 = rt;

    assign iss.valid  = valid_q;
    assign iss.alu_op = alu_op;
    assign iss.wd     = wd;
    assign iss.wreg   = known && wd != '0;  // $0 writes die here

    // every writing op must map to a result class
    a_write_has_class: assert property (
        @(posedge clk) disable iff (reset_i)
        (iss.valid && iss.wreg) |-> iss.alu_sel != core_pkg::SEL_NOP
    ) else $error("decoder write request without a result class");

endmodule

//--- verilog/operand_fwd.sv
module operand_fwd (
    issue_if.fwd            iss,
    regfile_rd_if.fwd       rd_if,
    input  core_pkg::word_t imm_i,
    input  core_pkg::wb_t   ex_fwd_i,
    input  core_pkg::wb_t   mem_fwd_i
);

    // newest producer wins, then regfile, immediate for unread ports
    function automatic core_pkg::word_t pick(
        input logic                re,
        input core_pkg::reg_addr_t raddr,
        input core_pkg::word_t     rdata,
        input core_pkg::word_t     imm,
        input core_pkg::wb_t       ex_fwd,
        input core_pkg::wb_t       mem_fwd
    );
        core_pkg::word_t res;
        if (re && ex_fwd.we && ex_fwd.addr == raddr) begin
            res = ex_fwd.data;
        end else if (re && mem_fwd.we && mem_fwd.addr == raddr) begin
            res = mem_fwd.data;
        end else if (re) begin
            res = rdata;
        end else begin
            res = imm;
        end
        return res;
    endfunction

    assign iss.opnd1 = pick(rd_if.re1, rd_if.raddr1, rd_if.rdata1, imm_i,
                            ex_fwd_i, mem_fwd_i);
    assign iss.opnd2 = pick(rd_if.re2, rd_if.raddr2, rd_if.rdata2, imm_i,
                            ex_fwd_i, mem_fwd_i);

endmodule

//--- verilog/ex_stage.sv
module ex_stage (
    input  logic          clk,
    input  logic          reset_i,
    issue_if.ex           iss,
    output core_pkg::wb_t ex_fwd_o
);

    logic                  valid_q;
    logic                  wreg_q;
    core_pkg::alu_op_e     alu_op_q;
    core_pkg::alu_sel_e    alu_sel_q;
    core_pkg::word_t       opnd1_q;
    core_pkg::word_t       opnd2_q;
    core_pkg::reg_addr_t   wd_q;

    logic [core_pkg::SHAMT_W-1:0] sh;
    core_pkg::word_t       logic_res;
    core_pkg::word_t       shift_res;
    core_pkg::word_t       arith_res;
    core_pkg::word_t       result;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            wreg_q  <= 1'b0;
        end else begin
            valid_q <= iss.valid;
            wreg_q  <= iss.wreg;
        end
        alu_op_q  <= iss.alu_op;
        alu_sel_q <= iss.alu_sel;
        opnd1_q   <= iss.opnd1;
        opnd2_q   <= iss.opnd2;
        wd_q      <= iss.wd;
    end

    assign sh = opnd1_q[core_pkg::SHAMT_W-1:0];  // shamt or rs[4:0]

    always_comb begin
        case (alu_op_q)
            core_pkg::ALU_AND: logic_res = opnd1_q & opnd2_q;
            core_pkg::ALU_OR:  logic_res = opnd1_q | opnd2_q;
            core_pkg::ALU_XOR: logic_res = opnd1_q ^ opnd2_q;
            core_pkg::ALU_NOR: logic_res = ~(opnd1_q | opnd2_q);
            default:           logic_res = '0;
        endcase
    end

    always_comb begin
        case (alu_op_q)
            core_pkg::ALU_SLL: shift_res = opnd2_q << sh;
            core_pkg::ALU_SRL: shift_res = opnd2_q >> sh;
            core_pkg::ALU_SRA: shift_res = core_pkg::word_t'($signed(opnd2_q) >>> sh);
            default:           shift_res = '0;
        endcase
    end

    always_comb begin
        case (alu_op_q)
            core_pkg::ALU_ADD:  arith_res = opnd1_q + opnd2_q;
            core_pkg::ALU_SUB:  arith_res = opnd1_q - opnd2_q;
            core_pkg::ALU_SLT:  arith_res = core_pkg::word_t'($signed(opnd1_q) < $signed(opnd2_q));
            core_pkg::ALU_SLTU: arith_res = core_pkg::word_t'(opnd1_q < opnd2_q);
            default:            arith_res = '0;
        endcase
    end

    always_comb begin
        case (alu_sel_q)
            core_pkg::SEL_LOGIC: result = logic_res;
            core_pkg::SEL_SHIFT: result = shift_res;
            core_pkg::SEL_ARITH: result = arith_res;
            default:             result = '0;
        endcase
    end

    assign ex_fwd_o.we   = valid_q && wreg_q;  // bubbles never write
    assign ex_fwd_o.addr = wd_q;
    assign ex_fwd_o.data = result;

    a_arith_not_logic: assert property (
        @(posedge clk) disable iff (reset_i)
        (iss.valid && iss.alu_sel == core_pkg::SEL_ARITH) |->
            !(iss.alu_op inside {core_pkg::ALU_AND, core_pkg::ALU_OR,
                                 core_pkg::ALU_XOR, core_pkg::ALU_NOR})
    ) else $error("arith request with a logic operation");

endmodule

//--- verilog/mem_wb_stage.sv
module mem_wb_stage (
    input  logic                clk,
    input  logic                reset_i,
    input  core_pkg::wb_t       ex_fwd_i,
    output core_pkg::wb_t       mem_fwd_o,
    output logic                wb_we_o,
    output core_pkg::reg_addr_t wb_addr_o,
    output core_pkg::word_t     wb_data_o
);

    core_pkg::wb_t mem_q;
    core_pkg::wb_t wb_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_q.we <= 1'b0;
            wb_q.we  <= 1'b0;
        end else begin
            mem_q.we <= ex_fwd_i.we;
            wb_q.we  <= mem_q.we;
        end
        mem_q.addr <= ex_fwd_i.addr;
        mem_q.data <= ex_fwd_i.data;
        wb_q.addr  <= mem_q.addr;  // report lags the regfile write by one edge
        wb_q.data  <= mem_q.data;
    end

    assign mem_fwd_o = mem_q;  // also the regfile write port

    assign wb_we_o   = wb_q.we;
    assign wb_addr_o = wb_q.addr;
    assign wb_data_o = wb_q.data;

endmodule

//--- verilog/mips_core.sv
module mips_core (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                inst_valid_i,
    input  core_pkg::word_t     inst_i,
    output logic                wb_we_o,
    output core_pkg::reg_addr_t wb_addr_o,
    output core_pkg::word_t     wb_data_o
);

    issue_if      iss ();
    regfile_rd_if rd_if ();

    core_pkg::word_t imm;
    core_pkg::wb_t   ex_fwd;   // combinational execute result
    core_pkg::wb_t   mem_fwd;  // registered, feeds the regfile write

    inst_decoder dec0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .iss          (iss.dec),
        .rd_if        (rd_if.dec),
        .imm_o        (imm)
    );

    regfile rf0 (
        .clk     (clk),
        .reset_i (reset_i),
        .rd_if   (rd_if.rf),
        .wr_i    (mem_fwd)
    );

    operand_fwd fwd0 (
        .iss       (iss.fwd),
        .rd_if     (rd_if.fwd),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd),
        .mem_fwd_i (mem_fwd)
    );

    ex_stage ex0 (
        .clk      (clk),
        .reset_i  (reset_i),
        .iss      (iss.ex),
        .ex_fwd_o (ex_fwd)
    );

    mem_wb_stage mem0 (
        .clk       (clk),
        .reset_i   (reset_i),
        .ex_fwd_i  (ex_fwd),
        .mem_fwd_o (mem_fwd),
        .wb_we_o   (wb_we_o),
        .wb_addr_o (wb_addr_o),
        .wb_data_o (wb_data_o)
    );

endmodule

//--- testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// 16-bit fibonacci lfsr, taps 16 14 13 11, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        r      = {r[30:0], fb};
    end
    return r;
endfunction

function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [4:0] rd,
                                      input logic [4:0] sa);
    return {core_pkg::OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// executes one instruction on the model register file
task automatic run_reference(input logic [31:0] inst, output logic we,
                             output logic [4:0] dest, output logic [31:0] val);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  sa;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] se;
    logic [31:0] ze;
    logic        known;
    op    = inst[31:26];
    fn    = inst[5:0];
    sa    = inst[10:6];
    a     = model_rf[inst[25:21]];
    b     = model_rf[inst[20:16]];
    se    = {{16{inst[15]}}, inst[15:0]};
    ze    = {16'h0000, inst[15:0]};
    known = 1'b1;
    val   = '0;
    if (op == core_pkg::OP_SPECIAL) begin
        dest = inst[15:11];
        case (fn)
            core_pkg::FN_AND:  val = a & b;
            core_pkg::FN_OR:   val = a | b;
            core_pkg::FN_XOR:  val = a ^ b;
            core_pkg::FN_NOR:  val = ~(a | b);
            core_pkg::FN_ADD,
            core_pkg::FN_ADDU: val = a + b;  // no trap
            core_pkg::FN_SUB,
            core_pkg::FN_SUBU: val = a - b;
            core_pkg::FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            core_pkg::FN_SLTU: val = (a < b) ? 32'd1 : 32'd0;
            core_pkg::FN_SLL:  val = b << sa;
            core_pkg::FN_SRL:  val = b >> sa;
            core_pkg::FN_SRA:  val = $signed(b) >>> sa;
            core_pkg::FN_SLLV: val = b << a[4:0];
            core_pkg::FN_SRLV: val = b >> a[4:0];
            core_pkg::FN_SRAV: val = $signed(b) >>> a[4:0];
            default:           known = 1'b0;
        endcase
    end else begin
        dest = inst[20:16];
        case (op)
            core_pkg::OP_ANDI:  val = a & ze;
            core_pkg::OP_ORI:   val = a | ze;
            core_pkg::OP_XORI:  val = a ^ ze;
            core_pkg::OP_LUI:   val = {inst[15:0], 16'h0000};
            core_pkg::OP_ADDI,
            core_pkg::OP_ADDIU: val = a + se;
            core_pkg::OP_SLTI:  val = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
            core_pkg::OP_SLTIU: val = (a < se) ? 32'd1 : 32'd0;
            default:            known = 1'b0;
        endcase
    end
    we = known && dest != 5'd0;
    if (we) begin
        model_rf[dest] = val;
    end
endtask

`endif

//--- testbench/tb_mips_core.sv
module tb_mips_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [15:0] SEED      = 16'd47374;
    localparam int          NUM_TESTS = 6;
    localparam int          WATCHDOG_CYCLES = NUM_TESTS * 200;

    logic                clk;
    logic                reset_i;
    logic                inst_valid_i;
    core_pkg::word_t     inst_i;
    logic                wb_we_o;
    core_pkg::reg_addr_t wb_addr_o;
    core_pkg::word_t     wb_data_o;

    logic [15:0] lfsr_q;
    logic [31:0] model_rf [32];
    logic [4:0]  exp_addr [1024];
    logic [31:0] exp_data [1024];
    logic [9:0]  wr_ptr = '0;
    logic [9:0]  rd_ptr = '0;
    logic        drv_wr;  // issued instruction is expected to write
    logic [3:0]  wr_pipe;
    int          cyc = 0;
    int          last_acc = -100;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;

    `include "tb_model.svh"

    mips_core dut0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_we_o      (wb_we_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (inst_valid_i) begin
            last_acc <= cyc;
        end
        if (reset_i) begin
            wr_pipe <= '0;
        end else begin
            wr_pipe <= {wr_pipe[2:0], inst_valid_i && drv_wr};
        end
        if (wb_we_o) begin  // pop after the negedge compare
            rd_ptr <= rd_ptr + 10'd1;
            checks <= checks + 1;
        end
    end

    a_wb_latency: assert property (@(negedge clk) disable iff (reset_i)
        wb_we_o == wr_pipe[3]
    ) else begin
        $display("CHECK FAILED wb_we_o got %h expected %h", wb_we_o, wr_pipe[3]);
        errors++;
    end

    a_wb_expected: assert property (@(negedge clk) disable iff (reset_i)
        wb_we_o |-> rd_ptr != wr_ptr
    ) else begin
        $display("write-back seen with no expected write-back queued");
        errors++;
    end

    a_wb_addr: assert property (@(negedge clk) disable iff (reset_i)
        (wb_we_o && rd_ptr != wr_ptr) |-> wb_addr_o == exp_addr[rd_ptr]
    ) else begin
        $display("CHECK FAILED wb_addr_o got %h expected %h", wb_addr_o, exp_addr[rd_ptr]);
        errors++;
    end

    a_wb_data: assert property (@(negedge clk) disable iff (reset_i)
        (wb_we_o && rd_ptr != wr_ptr) |-> wb_data_o == exp_data[rd_ptr]
    ) else begin
        $display("CHECK FAILED wb_data_o got %h expected %h", wb_data_o, exp_data[rd_ptr]);
        errors++;
    end

    a_queue_drained: assert property (@(negedge clk) disable iff (reset_i)
        (cyc == last_acc + 5) |-> rd_ptr == wr_ptr
    ) else begin
        $display("expected write-backs still pending after the last issue");
        errors++;
    end

    task automatic issue(input logic [31:0] inst);
        logic        we;
        logic [4:0]  dest;
        logic [31:0] val;
        run_reference(inst, we, dest, val);
        @(posedge clk);
        inst_valid_i <= 1'b1;
        inst_i       <= inst;
        drv_wr       <= we;
        if (we) begin
            exp_addr[wr_ptr] = dest;
            exp_data[wr_ptr] = val;
            wr_ptr = wr_ptr + 10'd1;
        end
    endtask

    task automatic bubble(input int n);
        repeat (n) begin
            @(posedge clk);
            inst_valid_i <= 1'b0;
            drv_wr       <= 1'b0;
        end
    endtask

    task automatic issue_spaced(input logic [31:0] inst);
        issue(inst);
        bubble(3);  // result already in the regfile
    endtask

    task automatic drain_and_report(input string name, input int err_start);
        bubble(1);
        while (rd_ptr != wr_ptr) begin
            bubble(1);
        end
        bubble(2);
        tests_run++;
        $display("test %s: %0d errors", name, errors - err_start);
    endtask

    function automatic logic [31:0] random_inst();
        logic [4:0]  sel;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [5:0]  code;
        sel = 5'(rand_bits(5) % 24);
        rs  = 5'(rand_bits(3));  // few registers, many hazards
        rt  = 5'(rand_bits(3));
        rd  = 5'(rand_bits(3));
        imm = 16'(rand_bits(16));
        case (sel)
            0:       code = core_pkg::FN_AND;
            1:       code = core_pkg::FN_OR;
            2:       code = core_pkg::FN_XOR;
            3:       code = core_pkg::FN_NOR;
            4:       code = core_pkg::FN_ADD;
            5:       code = core_pkg::FN_ADDU;
            6:       code = core_pkg::FN_SUB;
            7:       code = core_pkg::FN_SUBU;
            8:       code = core_pkg::FN_SLT;
            9:       code = core_pkg::FN_SLTU;
            10:      code = core_pkg::FN_SLL;
            11:      code = core_pkg::FN_SRL;
            12:      code = core_pkg::FN_SRA;
            13:      code = core_pkg::FN_SLLV;
            14:      code = core_pkg::FN_SRLV;
            15:      code = core_pkg::FN_SRAV;
            16:      code = core_pkg::OP_ANDI;
            17:      code = core_pkg::OP_ORI;
            18:      code = core_pkg::OP_XORI;
            19:      code = core_pkg::OP_LUI;
            20:      code = core_pkg::OP_ADDI;
            21:      code = core_pkg::OP_ADDIU;
            22:      code = core_pkg::OP_SLTI;
            default: code = core_pkg::OP_SLTIU;
        endcase
        if (sel < 16) begin
            return enc_r(code, rs, rt, rd, imm[10:6]);
        end
        return enc_i(code, rs, rt, imm);
    endfunction

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int e0;
        int gap;
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        drv_wr       = 1'b0;
        lfsr_q       = SEED;
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
        end
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;

        e0 = errors;  // first write-back latency
        bubble(5);
        issue(enc_i(core_pkg::OP_ORI, 5'd0, 5'd1, 16'h1234));
        drain_and_report("reset_latency", e0);

        e0 = errors;
        issue_spaced(enc_i(core_pkg::OP_ORI, 5'd0, 5'd2, 16'h8001));
        issue_spaced(enc_i(core_pkg::OP_ANDI, 5'd2, 5'd3, 16'hffff));
        issue_spaced(enc_i(core_pkg::OP_XORI, 5'd2, 5'd4, 16'hf0f0));
        issue_spaced(enc_i(core_pkg::OP_LUI, 5'd0, 5'd5, 16'h8765));
        issue_spaced(enc_i(core_pkg::OP_ADDI, 5'd0, 5'd6, 16'hfff0));
        issue_spaced(enc_i(core_pkg::OP_ADDIU, 5'd5, 5'd7, 16'h8000));
        issue_spaced(enc_i(core_pkg::OP_SLTI, 5'd6, 5'd8, 16'h0001));
        issue_spaced(enc_i(core_pkg::OP_SLTIU, 5'd6, 5'd9, 16'h0001));
        issue_spaced(enc_i(core_pkg::OP_SLTI, 5'd2, 5'd10, 16'hffff));
        issue_spaced(enc_i(core_pkg::OP_SLTIU, 5'd2, 5'd11, 16'hffff));
        drain_and_report("immediates", e0);

        e0 = errors;
        issue_spaced(enc_r(core_pkg::FN_AND, 5'd5, 5'd6, 5'd12, 5'd0));
        issue_spaced(enc_r(core_pkg::FN_OR, 5'd2, 5'd5, 5'd13, 5'd0));
        issue_spaced(enc_r(core_pkg::FN_XOR, 5'd4, 5'd6, 5'd14, 5'd0));
        issue_spaced(enc_r(core_pkg::FN_NOR, 5'd2, 5'd4, 5'd15, 5'd0));
        issue_spaced(enc_r(core_pkg::FN_ADD, 5'd5, 5'd5, 5'd16, 5'd0));  // wraps
        issue_spaced(enc_r(core_pkg::FN_ADDU, 5'd6, 5'd2, 5'd17, 5'd0));
        issue_spaced(enc_r(core_pkg::FN_SUB, 5'd0, 5'd6, 5'd18, 5'd0));
        issue_spaced(enc_r(core_pkg::FN_SUBU, 5'd2, 5'd5, 5'd19, 5'd0));
        issue_spaced(enc_r(core_pkg::FN_SLT, 5'd6, 5'd2, 5'd20, 5'd0));
        issue_spaced(enc_r(core_pkg::FN_SLTU, 5'd6, 5'd2, 5'd21, 5'd0));
        issue_spaced(enc_r(core_pkg::FN_SLL, 5'd0, 5'd5, 5'd22, 5'd4));
        issue_spaced(enc_r(core_pkg::FN_SRL, 5'd0, 5'd5, 5'd23, 5'd7));
        issue_spaced(enc_r(core_pkg::FN_SRA, 5'd0, 5'd5, 5'd24, 5'd7));
        issue_spaced(enc_r(core_pkg::FN_SLLV, 5'd6, 5'd2, 5'd25, 5'd0));
        issue_spaced(enc_r(core_pkg::FN_SRLV, 5'd2, 5'd6, 5'd26, 5'd0));
        issue_spaced(enc_r(core_pkg::FN_SRAV, 5'd4, 5'd5, 5'd27, 5'd0));
        drain_and_report("rtype", e0);

        e0 = errors;
        issue(enc_i(core_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h0005));
        issue(enc_i(core_pkg::OP_ADDIU, 5'd0, 5'd2, 16'h0007));
        issue(enc_r(core_pkg::FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0));  // mem and ex forward
        issue(enc_r(core_pkg::FN_SUBU, 5'd2, 5'd1, 5'd4, 5'd0));  // mem and regfile
        issue(enc_i(core_pkg::OP_ADDIU, 5'd0, 5'd5, 16'h0001));
        issue(enc_i(core_pkg::OP_ADDIU, 5'd0, 5'd5, 16'h0002));
        issue(enc_r(core_pkg::FN_ADDU, 5'd5, 5'd5, 5'd6, 5'd0));  // ex beats mem
        issue(enc_r(core_pkg::FN_SLLV, 5'd5, 5'd6, 5'd7, 5'd0));
        issue(enc_r(core_pkg::FN_XOR, 5'd7, 5'd3, 5'd8, 5'd0));
        issue(enc_i(core_pkg::OP_ORI, 5'd8, 5'd8, 16'h00f0));
        issue(enc_r(core_pkg::FN_SLT, 5'd4, 5'd8, 5'd9, 5'd0));
        drain_and_report("forwarding", e0);

        e0 = errors;
        issue(enc_r(6'b011000, 5'd1, 5'd2, 5'd0, 5'd0));  // mult
        issue(enc_r(6'b010000, 5'd0, 5'd0, 5'd3, 5'd0));  // mfhi
        issue({6'b011100, 5'd1, 5'd4, 5'd4, 5'd0, 6'b100000});  // clz
        issue(enc_r(6'b001011, 5'd1, 5'd2, 5'd5, 5'd0));  // movn
        issue(enc_i(core_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h0005));
        issue(enc_r(core_pkg::FN_ADDU, 5'd0, 5'd0, 5'd10, 5'd0));
        issue(enc_i(core_pkg::OP_ADDIU, 5'd0, 5'd11, 16'h0033));
        drain_and_report("dropped_and_zero", e0);

        e0 = errors;
        for (int n = 0; n < 200; n++) begin
            issue(random_inst());
            gap = int'(rand_bits(2));
            bubble(gap);
        end
        drain_and_report("random_stream", e0);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+testbench
verilog/core_pkg.sv
verilog/core_ifs.sv
verilog/regfile.sv
verilog/inst_decoder.sv
verilog/operand_fwd.sv
verilog/ex_stage.sv
verilog/mem_wb_stage.sv
verilog/mips_core.sv
testbench/tb_mips_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module tb_mips_core -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST OK" sim.log
